/* list.f */
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_load_align.sv
rv_wb.sv
rv_regfile.sv
rv_wb_top.sv
rv_wb_properties.sv
tb_rv_wb.sv

/* Bender.yml */
package:
  name: rv_wb

sources:
  - rv_isa_pkg.sv
  - rv_pipe_pkg.sv
  - rv_load_align.sv
  - rv_wb.sv
  - rv_regfile.sv
  - rv_wb_top.sv
  - target: test
    files:
      - rv_wb_properties.sv
      - tb_rv_wb.sv

/* tb_rv_wb.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_rv_wb;

  localparam real         CLK_PERIOD = 8.0;
  // ALU, idle, loads, stores and the like, faults, illegal, final idle
  localparam int          NUM_INSTR  = 18 + 1 + 5 * 4 + 2 * 3 + 2 * 3 * 2 + 2 * 2 + 1;
  // addi x0, x0, 0
  localparam logic [31:0] NOP        = 32'h0000_0013;

  // Expected stage state for one accepted instruction
  typedef struct packed {
    logic [31:0]           pc;
    logic [31:0]           instr;
    logic [31:0]           r;
    logic [31:0]           bad;
    logic                  we;
    logic                  bubble;
    logic                  dbg;
    logic [4:0]            dst;
    rv_pipe_pkg::exc_vec_t exc;
  } exp_t;

  logic clk_i, rst_ni;
  logic [31:0] mem_pc_i, mem_instr_i, mem_r_i, mem_adr_i, dmem_q_i;
  logic mem_bubble_i, mem_dbg_i;
  rv_pipe_pkg::exc_vec_t mem_exc_i, wb_exc_o;
  logic dmem_ack_i, dmem_err_i, dmem_misaligned_i, dmem_page_fault_i;
  logic wb_stall_o, wb_bubble_o, wb_dbg_o, wb_exc_any_o, wb_we_o;
  logic [31:0] wb_pc_o, wb_instr_o, wb_badaddr_o, wb_memq_o, wb_r_o, rd1_o, rd2_o;
  rv_isa_pkg::reg_idx_t wb_dst_o, rs1_i, rs2_i;

  int          seed = 6100;
  int          errors = 0;
  logic        prev_exc = 1'b0;
  logic [31:0] pc = rv_pipe_pkg::PC_INIT;
  logic [31:0] shadow [0:31];
  exp_t        exp_q [$];

  rv_wb_top dut0 (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      errors++;
      $display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic void ref_wb(
    input  logic [31:0] instr, input logic bubble, input rv_pipe_pkg::exc_vec_t exc_in,
    input  logic [31:0] r, input logic [31:0] adr, input logic [31:0] q,
    input  logic err, input logic mis, input logic pf, input logic prev,
    output logic [31:0] res, output logic we, output logic [4:0] dst,
    output rv_pipe_pkg::exc_vec_t exc, output logic [31:0] bad
  );
    logic [4:0]  opc;
    logic [31:0] sh;
    opc = instr[6:2];
    dst = instr[11:7];
    exc = exc_in;
    // Memory strobes replace the memory causes of a live access
    if (!bubble && opc == rv_isa_pkg::OPC_LOAD)
    begin
      exc[rv_pipe_pkg::EXC_MISALIGNED_LOAD] = mis;
      exc[rv_pipe_pkg::EXC_LOAD_FAULT]      = err;
      exc[rv_pipe_pkg::EXC_LOAD_PAGE]       = pf;
    end
    if (!bubble && opc == rv_isa_pkg::OPC_STORE)
    begin
      exc[rv_pipe_pkg::EXC_MISALIGNED_STORE] = mis;
      exc[rv_pipe_pkg::EXC_STORE_FAULT]      = err;
      exc[rv_pipe_pkg::EXC_STORE_PAGE]       = pf;
    end
    // Address causes and breakpoint report the address
    if (|exc[rv_pipe_pkg::EXC_STORE_PAGE:rv_pipe_pkg::EXC_BREAKPOINT])
      bad = adr;
    else if (exc[rv_pipe_pkg::EXC_ILLEGAL])
      bad = instr;
    else
      bad = '0;
    // Load value picked from the addressed lane
    sh = q >> (8 * adr[1:0]);
    res = r;
    if (opc == rv_isa_pkg::OPC_LOAD)
    begin
      case (instr[14:12])
        rv_isa_pkg::F3_LB:  res = {{24{sh[7]}}, sh[7:0]};
        rv_isa_pkg::F3_LH:  res = {{16{sh[15]}}, sh[15:0]};
        rv_isa_pkg::F3_LW:  res = sh;
        rv_isa_pkg::F3_LBU: res = {24'b0, sh[7:0]};
        rv_isa_pkg::F3_LHU: res = {16'b0, sh[15:0]};
        default:            res = '0;
      endcase
    end
    we = !(|exc) && !prev && !bubble && (dst != 0) && opc != rv_isa_pkg::OPC_STORE &&
         opc != rv_isa_pkg::OPC_BRANCH && opc != rv_isa_pkg::OPC_MISC_MEM;
  endfunction

  // Compare one cycle after each accepted instruction
  always @(negedge clk_i)
  begin
    exp_t e;
    if (exp_q.size() > 0)
    begin
      e = exp_q.pop_front();
      check_val("wb_pc_o", e.pc, wb_pc_o);
      check_val("wb_instr_o", e.instr, wb_instr_o);
      check_val("wb_we_o", e.we, wb_we_o);
      check_val("wb_bubble_o", e.bubble, wb_bubble_o);
      check_val("wb_dbg_o", e.dbg, wb_dbg_o);
      check_val("wb_exc_o", e.exc, wb_exc_o);
      check_val("wb_exc_any_o", |e.exc, wb_exc_any_o);
      check_val("wb_badaddr_o", e.bad, wb_badaddr_o);
      check_val("wb_dst_o", e.dst, wb_dst_o);
      if (!e.bubble && !(|e.exc))
        check_val("wb_r_o", e.r, wb_r_o);
      // Register file model follows the write port
      if (e.we)
        shadow[e.dst] = e.r;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Starts on a rising edge and returns on the edge that accepts it
  // Strobe picked by kind in the order ack, err, misaligned, page fault
  task automatic issue(input logic [31:0] instr, input logic bubble,
                       input rv_pipe_pkg::exc_vec_t exc_in, input logic [31:0] r,
                       input logic [31:0] adr, input int kind, input int delay);
    logic       memop, strobe_on, exp_stall, dbg, accepted;
    logic [3:0] strb;
    int         waited;
    exp_t       e;
    logic [31:0] q;
    memop = instr[6:2] == rv_isa_pkg::OPC_LOAD || instr[6:2] == rv_isa_pkg::OPC_STORE;
    q = $random(seed);
    dbg = $random(seed);
    strb = 4'b0001 << kind;
    strobe_on = memop && delay == 0;
    accepted = 1'b0;
    waited = 0;
    mem_pc_i <= pc;
    mem_instr_i <= instr;
    mem_bubble_i <= bubble;
    mem_dbg_i <= dbg;
    mem_exc_i <= exc_in;
    mem_r_i <= r;
    mem_adr_i <= adr;
    dmem_q_i <= q;
    {dmem_page_fault_i, dmem_misaligned_i, dmem_err_i, dmem_ack_i} <= strobe_on ? strb : 4'b0;
    // Memory answers after the chosen number of stalled edges
    while (!accepted)
    begin
      @(posedge clk_i);
      exp_stall = memop && !bubble && !(|exc_in) && !prev_exc && !strobe_on;
      check_val("wb_stall_o", exp_stall, wb_stall_o);
      if (!wb_stall_o)
        accepted = 1'b1;
      else
      begin
        waited++;
        if (memop && waited >= delay && !strobe_on)
        begin
          strobe_on = 1'b1;
          {dmem_page_fault_i, dmem_misaligned_i, dmem_err_i, dmem_ack_i} <= strb;
        end
      end
    end
    ref_wb(instr, bubble, exc_in, r, adr, q, strobe_on & strb[1], strobe_on & strb[2],
           strobe_on & strb[3], prev_exc, e.r, e.we, e.dst, e.exc, e.bad);
    // Early load result still reflects the accepted inputs
    if (instr[6:2] == rv_isa_pkg::OPC_LOAD)
      check_val("wb_memq_o", e.r, wb_memq_o);
    e.pc = pc;
    e.instr = instr;
    e.bubble = bubble | prev_exc;
    e.dbg = dbg;
    exp_q.push_back(e);
    prev_exc = |e.exc;
    pc = pc + 4;
  endtask

  task automatic idle();
    issue(NOP, 1'b1, '0, '0, '0, 0, 0);
  endtask

  // Read every register through both ports
  task automatic sweep_regs();
    for (int i = 0; i < 32; i++)
    begin
      rs1_i <= i;
      rs2_i <= 31 - i;
      @(negedge clk_i);
      check_val("rd1_o", shadow[i], rd1_o);
      check_val("rd2_o", shadow[31 - i], rd2_o);
      @(posedge clk_i);
    end
  endtask

  function automatic logic [31:0] make_instr(input logic [4:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd);
    logic [31:0] w;
    w = $random(seed);
    w[6:0] = {opc, 2'b11};
    w[11:7] = rd;
    w[14:12] = f3;
    return w;
  endfunction

  // Ends a run that stalls forever
  initial
  begin
    #(4.0 * NUM_INSTR * 4 * CLK_PERIOD);
    $display("Timeout: the stimulus did not finish in the allotted time");
    $display("Test failed");
    $finish;
  end

  initial
  begin
    logic [2:0] widths [5];
    logic [4:0] kinds [2];
    widths = '{rv_isa_pkg::F3_LB, rv_isa_pkg::F3_LH, rv_isa_pkg::F3_LW,
               rv_isa_pkg::F3_LBU, rv_isa_pkg::F3_LHU};
    kinds = '{rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_STORE};
    clk_i = 1'b0;
    rst_ni = 1'b0;
    mem_pc_i = '0;
    mem_instr_i = NOP;
    mem_bubble_i = 1'b1;
    mem_dbg_i = 1'b0;
    mem_exc_i = '0;
    mem_r_i = '0;
    mem_adr_i = '0;
    dmem_q_i = '0;
    {dmem_page_fault_i, dmem_misaligned_i, dmem_err_i, dmem_ack_i} = 4'b0;
    rs1_i = '0;
    rs2_i = '0;
    for (int i = 0; i < 32; i++)
      shadow[i] = '0;

    // Reset state
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_val("wb_we_o", 1'b0, wb_we_o);
    check_val("wb_bubble_o", 1'b1, wb_bubble_o);
    check_val("wb_dbg_o", 1'b0, wb_dbg_o);
    check_val("wb_exc_o", '0, wb_exc_o);
    check_val("wb_exc_any_o", 1'b0, wb_exc_any_o);
    check_val("wb_pc_o", rv_pipe_pkg::PC_INIT, wb_pc_o);
    check_val("wb_badaddr_o", '0, wb_badaddr_o);
    @(posedge clk_i);
    sweep_regs();

    // ALU write-back including rd zero
    for (int i = 0; i < 18; i++)
      issue(make_instr(rv_isa_pkg::OPC_OP, 3'b000, i < 2 ? 5'd0 : 5'($random(seed))),
            1'b0, '0, $random(seed), '0, 0, 0);
    // Read back before loads reuse the registers
    idle();
    sweep_regs();

    // Every load width at every byte lane
    for (int w = 0; w < 5; w++)
      for (int off = 0; off < 4; off++)
        issue(make_instr(rv_isa_pkg::OPC_LOAD, widths[w], 5'(1 + w * 4 + off)), 1'b0, '0,
              $random(seed), {30'($random(seed)), 2'(off)}, 0, {$random(seed)} % 4);

    // No write for stores, branches and fences
    for (int i = 0; i < 2; i++)
    begin
      issue(make_instr(rv_isa_pkg::OPC_STORE, 3'b010, 5'd3), 1'b0, '0, $random(seed),
            $random(seed), 0, {$random(seed)} % 4);
      issue(make_instr(rv_isa_pkg::OPC_BRANCH, 3'b000, 5'd5), 1'b0, '0, $random(seed),
            '0, 0, 0);
      issue(make_instr(rv_isa_pkg::OPC_MISC_MEM, 3'b000, 5'd7), 1'b0, '0, $random(seed),
            '0, 0, 0);
    end

    // Memory faults each followed by a killed instruction
    for (int k = 0; k < 2; k++)
      for (int f = 1; f < 4; f++)
      begin
        issue(make_instr(kinds[k], rv_isa_pkg::F3_LW, 5'd9), 1'b0, '0, $random(seed),
              $random(seed), f, {$random(seed)} % 4);
        issue(make_instr(rv_isa_pkg::OPC_OP, 3'b000, 5'd10), 1'b0, '0, $random(seed),
              '0, 0, 0);
      end

    // Illegal instruction
    for (int i = 0; i < 2; i++)
    begin
      issue(make_instr(rv_isa_pkg::OPC_OP_IMM, 3'b000, 5'd11), 1'b0,
            rv_pipe_pkg::exc_vec_t'(1) << rv_pipe_pkg::EXC_ILLEGAL, $random(seed),
            $random(seed), 0, 0);
      issue(make_instr(rv_isa_pkg::OPC_LUI, 3'b000, 5'd12), 1'b0, '0, $random(seed),
            '0, 0, 0);
    end

    idle();
    sweep_regs();
    @(negedge clk_i);
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("Compare queue still holds %0d entries at the end", exp_q.size());
    end
    $display("Run finished with %0d errors", errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_wb_properties.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_wb_properties
(
  input wire logic                        clk_i,
  input wire logic                        rst_ni,
  input wire logic                        wb_stall_o,
  input wire logic [rv_isa_pkg::XLEN-1:0] wb_pc_o,
  input wire rv_pipe_pkg::exc_vec_t       wb_exc_o,
  input wire logic                        wb_dbg_o,
  input wire logic                        wb_bubble_o,
  input wire logic                        wb_we_o,
  input wire logic                        wb_exc_any_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Stage register behaviour
  ////////////////////////////////////////////////////////////////////////////

  // Stalled edge leaves the stage state untouched
  stall_holds_state: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_stall_o |=> ($stable(wb_pc_o) && $stable(wb_exc_o) &&
                    $stable(wb_dbg_o) && $stable(wb_bubble_o))
  ) else $error("stage state changed during a stall");

  // Trapped instruction never writes
  no_write_on_trap: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(wb_we_o && wb_exc_any_o)
  ) else $error("write enable together with an exception");

  // Bubble in write-back never writes the register file
  no_write_on_bubble: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_bubble_o |-> !wb_we_o
  ) else $error("write enable raised for a bubble");

endmodule

bind rv_wb rv_wb_properties u_props (.*);

`default_nettype wire

/* rv_wb_top.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_wb_top
(
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,

  // Memory stage
  input  wire logic [rv_isa_pkg::XLEN-1:0] mem_pc_i,
  input  wire logic [rv_isa_pkg::ILEN-1:0] mem_instr_i,
  input  wire logic                        mem_bubble_i,
  input  wire logic                        mem_dbg_i,
  input  wire rv_pipe_pkg::exc_vec_t       mem_exc_i,
  input  wire logic [rv_isa_pkg::XLEN-1:0] mem_r_i,
  input  wire logic [rv_isa_pkg::XLEN-1:0] mem_adr_i,

  // Data memory
  input  wire logic                        dmem_ack_i,
  input  wire logic                        dmem_err_i,
  input  wire logic                        dmem_misaligned_i,
  input  wire logic                        dmem_page_fault_i,
  input  wire logic [rv_isa_pkg::XLEN-1:0] dmem_q_i,

  // Write-back state
  output logic                             wb_stall_o,
  output logic      [rv_isa_pkg::XLEN-1:0] wb_pc_o,
  output logic      [rv_isa_pkg::ILEN-1:0] wb_instr_o,
  output logic                             wb_bubble_o,
  output logic                             wb_dbg_o,
  output rv_pipe_pkg::exc_vec_t            wb_exc_o,
  output logic                             wb_exc_any_o,
  output logic      [rv_isa_pkg::XLEN-1:0] wb_badaddr_o,
  output logic      [rv_isa_pkg::XLEN-1:0] wb_memq_o,
  output rv_isa_pkg::reg_idx_t             wb_dst_o,
  output logic      [rv_isa_pkg::XLEN-1:0] wb_r_o,
  output logic                             wb_we_o,

  // Register file read ports
  input  wire rv_isa_pkg::reg_idx_t        rs1_i,
  input  wire rv_isa_pkg::reg_idx_t        rs2_i,
  output logic      [rv_isa_pkg::XLEN-1:0] rd1_o,
  output logic      [rv_isa_pkg::XLEN-1:0] rd2_o
);

  rv_wb u_wb (.*);

  // Write port straight from the stage outputs
  rv_regfile u_regfile
  (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .we_i     (wb_we_o),
    .waddr_i  (wb_dst_o),
    .wdata_i  (wb_r_o),
    .raddr1_i (rs1_i),
    .raddr2_i (rs2_i),
    .rdata1_o (rd1_o),
    .rdata2_o (rd2_o)
  );

endmodule

`default_nettype wire

/* rv_regfile.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_regfile
(
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,

  // Write port from write-back
  input  wire logic                        we_i,
  input  wire rv_isa_pkg::reg_idx_t        waddr_i,
  input  wire logic [rv_isa_pkg::XLEN-1:0] wdata_i,

  // Read ports, asynchronous
  input  wire rv_isa_pkg::reg_idx_t        raddr1_i,
  input  wire rv_isa_pkg::reg_idx_t        raddr2_i,
  output logic      [rv_isa_pkg::XLEN-1:0] rdata1_o,
  output logic      [rv_isa_pkg::XLEN-1:0] rdata2_o
);

  // x0 has no storage
  logic [rv_isa_pkg::XLEN-1:0] regs [1:rv_isa_pkg::REG_N-1];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 1; i < rv_isa_pkg::REG_N; i++)
        regs[i] <= '0;
    end
    else if (we_i && (waddr_i != '0))
    begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Written value visible from the cycle after the write edge
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* rv_wb.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_wb
(
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,

  // Memory stage
  input  wire logic [rv_isa_pkg::XLEN-1:0]   mem_pc_i,
  input  wire logic [rv_isa_pkg::ILEN-1:0]   mem_instr_i,
  input  wire logic                          mem_bubble_i,
  input  wire logic                          mem_dbg_i,
  input  wire rv_pipe_pkg::exc_vec_t         mem_exc_i,
  input  wire logic [rv_isa_pkg::XLEN-1:0]   mem_r_i,
  input  wire logic [rv_isa_pkg::XLEN-1:0]   mem_adr_i,

  // Data memory, level strobes
  input  wire logic                          dmem_ack_i,
  input  wire logic                          dmem_err_i,
  input  wire logic                          dmem_misaligned_i,
  input  wire logic                          dmem_page_fault_i,
  input  wire logic [rv_isa_pkg::XLEN-1:0]   dmem_q_i,

  // Back-pressure to memory stage
  output logic                               wb_stall_o,

  // Write-back state
  output logic      [rv_isa_pkg::XLEN-1:0]   wb_pc_o,
  output logic      [rv_isa_pkg::ILEN-1:0]   wb_instr_o,
  output logic                               wb_bubble_o,
  output logic                               wb_dbg_o,
  output rv_pipe_pkg::exc_vec_t              wb_exc_o,
  output logic                               wb_exc_any_o,
  output logic      [rv_isa_pkg::XLEN-1:0]   wb_badaddr_o,

  // Early load result, feeds back before the stage register
  output logic      [rv_isa_pkg::XLEN-1:0]   wb_memq_o,

  // Register file write port
  output rv_isa_pkg::reg_idx_t               wb_dst_o,
  output logic      [rv_isa_pkg::XLEN-1:0]   wb_r_o,
  output logic                               wb_we_o
);

  logic [4:0]            opcode;
  rv_isa_pkg::reg_idx_t  dst;
  logic                  is_load;
  logic                  is_store;
  logic                  dmem_any;
  rv_pipe_pkg::exc_vec_t exc;
  logic                  exc_any;
  logic                  exc_mem_bp;

  //////////////////////////////////////////////////////////////////////////////
  // Decode and load data
  //////////////////////////////////////////////////////////////////////////////

  assign opcode   = rv_pipe_pkg::get_opcode(mem_instr_i);
  assign dst      = rv_pipe_pkg::get_rd(mem_instr_i);
  assign is_load  = (opcode == rv_isa_pkg::OPC_LOAD);
  assign is_store = (opcode == rv_isa_pkg::OPC_STORE);

  // Any answer from memory ends the wait
  assign dmem_any = dmem_ack_i | dmem_err_i | dmem_misaligned_i | dmem_page_fault_i;

  rv_load_align u_load_align
  (
    .data_i     (dmem_q_i),
    .byte_sel_i (mem_adr_i[1:0]),
    .funct3_i   (mem_instr_i[rv_isa_pkg::F3_MSB:rv_isa_pkg::F3_LSB]),
    .data_o     (wb_memq_o)
  );

  //////////////////////////////////////////////////////////////////////////////
  // Stall
  //////////////////////////////////////////////////////////////////////////////

  // Wait for memory only on a live access with no trap pending
  assign wb_stall_o = (is_load | is_store) & ~mem_bubble_i & ~(|mem_exc_i) &
                      ~wb_exc_any_o & ~dmem_any;

  //////////////////////////////////////////////////////////////////////////////
  // Exception merge
  //////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    exc = mem_exc_i;
    // Memory strobes override the incoming memory causes
    if (is_load && !mem_bubble_i)
    begin
      exc[rv_pipe_pkg::EXC_MISALIGNED_LOAD] = dmem_misaligned_i;
      exc[rv_pipe_pkg::EXC_LOAD_FAULT]      = dmem_err_i;
      exc[rv_pipe_pkg::EXC_LOAD_PAGE]       = dmem_page_fault_i;
    end
    if (is_store && !mem_bubble_i)
    begin
      exc[rv_pipe_pkg::EXC_MISALIGNED_STORE] = dmem_misaligned_i;
      exc[rv_pipe_pkg::EXC_STORE_FAULT]      = dmem_err_i;
      exc[rv_pipe_pkg::EXC_STORE_PAGE]       = dmem_page_fault_i;
    end
  end

  // Interrupts included, any set bit traps
  assign exc_any = |exc;

  // Causes that report the data address
  assign exc_mem_bp = exc[rv_pipe_pkg::EXC_MISALIGNED_LOAD]  |
                      exc[rv_pipe_pkg::EXC_MISALIGNED_STORE] |
                      exc[rv_pipe_pkg::EXC_LOAD_FAULT]       |
                      exc[rv_pipe_pkg::EXC_STORE_FAULT]      |
                      exc[rv_pipe_pkg::EXC_LOAD_PAGE]        |
                      exc[rv_pipe_pkg::EXC_STORE_PAGE]       |
                      exc[rv_pipe_pkg::EXC_BREAKPOINT];

  //////////////////////////////////////////////////////////////////////////////
  // Stage registers
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wb_pc_o      <= rv_pipe_pkg::PC_INIT;
      wb_dbg_o     <= 1'b0;
      wb_exc_o     <= '0;
      wb_exc_any_o <= 1'b0;
    end
    else if (!wb_stall_o)
    begin
      wb_pc_o      <= mem_pc_i;
      wb_dbg_o     <= mem_dbg_i;
      wb_exc_o     <= exc;
      wb_exc_any_o <= exc_any;
    end
  end

  // Payload, no reset
  always_ff @(posedge clk_i)
  begin
    if (!wb_stall_o)
    begin
      wb_instr_o <= mem_instr_i;
      wb_dst_o   <= dst;
      wb_r_o     <= is_load ? wb_memq_o : mem_r_i;
    end
  end

  // Trap value, sampled every clock
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_badaddr_o <= '0;
    else if (exc_mem_bp)
      wb_badaddr_o <= mem_adr_i;
    else if (exc[rv_pipe_pkg::EXC_ILLEGAL])
      wb_badaddr_o <= mem_instr_i[0 +: rv_isa_pkg::XLEN];
    else
      wb_badaddr_o <= '0;
  end

  //////////////////////////////////////////////////////////////////////////////
  // Write enable and bubble
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_we_o <= 1'b0;
    else if (exc_any || wb_exc_any_o)
      wb_we_o <= 1'b0;
    else
    begin
      case (opcode)
        rv_isa_pkg::OPC_STORE,
        rv_isa_pkg::OPC_BRANCH,
        rv_isa_pkg::OPC_MISC_MEM: wb_we_o <= 1'b0;
        // Loads write only once the data is in
        rv_isa_pkg::OPC_LOAD:     wb_we_o <= ~mem_bubble_i & (|dst) & ~wb_stall_o;
        default:                  wb_we_o <= ~mem_bubble_i & (|dst);
      endcase
    end
  end

  // Trap kills what follows
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_bubble_o <= 1'b1;
    else if (wb_exc_any_o)
      wb_bubble_o <= 1'b1;
    else if (!wb_stall_o)
      wb_bubble_o <= mem_bubble_i;
  end

endmodule

`default_nettype wire

/* rv_load_align.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_load_align
(
  input  wire logic [rv_isa_pkg::XLEN-1:0] data_i,
  input  wire logic [1:0]                  byte_sel_i,
  input  wire logic [2:0]                  funct3_i,
  output logic      [rv_isa_pkg::XLEN-1:0] data_o
);

  // Bus word moved down to the addressed lane
  logic [rv_isa_pkg::XLEN-1:0] data_sh;
  logic [7:0]                  q_byte;
  logic [15:0]                 q_half;

  // Byte lane times eight gives the bit shift
  assign data_sh = data_i >> {byte_sel_i, 3'b000};
  assign q_byte  = data_sh[7:0];
  assign q_half  = data_sh[15:0];

  // Width and extension by funct3
  always_comb
  begin
    case (funct3_i)
      rv_isa_pkg::F3_LB:
        data_o = {{(rv_isa_pkg::XLEN-8){q_byte[7]}}, q_byte};
      rv_isa_pkg::F3_LH:
        data_o = {{(rv_isa_pkg::XLEN-16){q_half[15]}}, q_half};
      // Full word from the shifted lane, zero fill on an offset
      rv_isa_pkg::F3_LW:
        data_o = data_sh;
      rv_isa_pkg::F3_LBU:
        data_o = {{(rv_isa_pkg::XLEN-8){1'b0}}, q_byte};
      rv_isa_pkg::F3_LHU:
        data_o = {{(rv_isa_pkg::XLEN-16){1'b0}}, q_half};
      // Reserved encodings
      default:
        data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // Pipeline state
  //////////////////////////////////////////////////////////////////////////////

  // Program counter value out of reset
  localparam logic [rv_isa_pkg::XLEN-1:0] PC_INIT = 'h200;

  // Cause vector width, one bit per cause
  localparam int EXC_W = 10;

  // Synchronous exception causes
  localparam int EXC_ILLEGAL          = 0;
  localparam int EXC_BREAKPOINT       = 1;
  // Memory causes, replaced by the data memory strobes
  localparam int EXC_MISALIGNED_LOAD  = 2;
  localparam int EXC_MISALIGNED_STORE = 3;
  localparam int EXC_LOAD_FAULT       = 4;
  localparam int EXC_STORE_FAULT      = 5;
  localparam int EXC_LOAD_PAGE        = 6;
  localparam int EXC_STORE_PAGE       = 7;
  // Asynchronous sources, carried only
  localparam int EXC_IRQ              = 8;
  localparam int EXC_NMI              = 9;

  // Packed cause vector, any bit set means trap
  typedef logic [EXC_W-1:0] exc_vec_t;

  //////////////////////////////////////////////////////////////////////////////
  // Decode helpers
  //////////////////////////////////////////////////////////////////////////////

  // Major opcode of a 32-bit instruction word
  function automatic logic [4:0] get_opcode(
    input logic [rv_isa_pkg::ILEN-1:0] instr
  );
    return instr[rv_isa_pkg::OPC_MSB:rv_isa_pkg::OPC_LSB];
  endfunction

  // Destination register index
  // Not qualified by opcode, the caller decides whether rd is written
  function automatic rv_isa_pkg::reg_idx_t get_rd(
    input logic [rv_isa_pkg::ILEN-1:0] instr
  );
    return instr[rv_isa_pkg::RD_MSB:rv_isa_pkg::RD_LSB];
  endfunction

endpackage

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // Base sizes
  //////////////////////////////////////////////////////////////////////////////

  // RV32 only, no 64-bit loads
  localparam int XLEN = 32;

  // Base instruction length, no compressed forms here
  localparam int ILEN = 32;

  // Architectural integer registers
  localparam int REG_N = 32;
  localparam int REG_IDX_W = $clog2(REG_N);

  // Register index as carried through the pipe
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  //////////////////////////////////////////////////////////////////////////////
  // Instruction field positions
  //////////////////////////////////////////////////////////////////////////////

  // Major opcode, low two bits always 2'b11 for 32-bit forms
  localparam int OPC_LSB = 2;
  localparam int OPC_MSB = 6;

  // Destination register
  localparam int RD_LSB = 7;
  localparam int RD_MSB = 11;

  // Minor opcode, selects load width
  localparam int F3_LSB = 12;
  localparam int F3_MSB = 14;

  //////////////////////////////////////////////////////////////////////////////
  // Major opcodes, instruction bits 6 to 2
  //////////////////////////////////////////////////////////////////////////////

  localparam logic [4:0] OPC_LOAD     = 5'b00000;
  localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
  localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
  localparam logic [4:0] OPC_STORE    = 5'b01000;
  localparam logic [4:0] OPC_OP       = 5'b01100;
  localparam logic [4:0] OPC_LUI      = 5'b01101;
  localparam logic [4:0] OPC_BRANCH   = 5'b11000;
  localparam logic [4:0] OPC_SYSTEM   = 5'b11100;

  //////////////////////////////////////////////////////////////////////////////
  // Load widths (funct3)
  //////////////////////////////////////////////////////////////////////////////

  // Signed loads
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  // Unsigned loads, bit 2 set
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

endpackage

`default_nettype wire
